// File: src/configUartPkg.sv
// shared constants for the serial configuration loader
package configUartPkg;

    // line timing
    localparam int unsigned CLOCK_FREQUENCY = 50_000_000;  // system clock in Hz
    localparam int unsigned BAUD_RATE = 115_200;

    // bit-rate counter counts COM_RATE clock cycles per bit
    localparam int COM_COUNT_BITS = 12;
    localparam logic [COM_COUNT_BITS-1:0] COM_RATE =
        COM_COUNT_BITS'(CLOCK_FREQUENCY / BAUD_RATE);  // 434 at 50 MHz

    // quiet line period that closes a session
    localparam logic [14:0] TIMEOUT_CYCLES = 15'd16777;

    // header is three id bytes and a command byte
    localparam logic [23:0] HEADER_ID = 24'h00AAFF;

    // command byte layout
    // bit 7 selects ASCII hex payload over binary
    localparam int CMD_HEX_BIT = 7;
    localparam logic [6:0] CMD_LOAD_A = 7'd1;
    localparam logic [6:0] CMD_LOAD_B = 7'd2;

    // payload is packed msb first into 32-bit words
    localparam int BYTES_PER_WORD = 4;

endpackage

// File: src/uartByteReceiver.sv
`timescale 1ns/1ps

// 8N1 receiver sampling each bit in the middle of its period
module uartByteReceiver (
    input  logic       CLK,
    input  logic       resetn,
    input  logic       Rx,
    output logic [7:0] rxByte,
    output logic       byteValid
);
    import configUartPkg::*;

    localparam logic [1:0] WAIT_START = 2'd0;
    localparam logic [1:0] START_BIT  = 2'd1;
    localparam logic [1:0] DATA_BITS  = 2'd2;
    localparam logic [1:0] STOP_BIT   = 2'd3;

    logic                      rxSync;
    logic [COM_COUNT_BITS-1:0] comCount;
    logic                      comTick;
    logic [1:0]                state;
    logic [2:0]                bitIndex;

    // Rx is asynchronous to CLK
    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            rxSync <= 1'b1;  // idle line
        end else begin
            rxSync <= Rx;
        end
    end

    // half a period first so that later ticks land mid-bit
    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            comCount <= '0;
            comTick  <= 1'b0;
        end else if (state == WAIT_START) begin
            comCount <= COM_RATE >> 1;
            comTick  <= 1'b0;
        end else if (comCount == '0) begin
            comCount <= COM_RATE - 1'b1;
            comTick  <= 1'b1;
        end else begin
            comCount <= comCount - 1'b1;
            comTick  <= 1'b0;
        end
    end

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            state    <= WAIT_START;
            bitIndex <= 3'd0;
            rxByte   <= 8'h00;
        end else begin
            case (state)
                WAIT_START: begin
                    if (!rxSync) state <= START_BIT;
                end
                START_BIT: begin
                    if (comTick) begin
                        state    <= DATA_BITS;
                        bitIndex <= 3'd0;
                    end
                end
                DATA_BITS: begin
                    if (comTick) begin
                        rxByte   <= {rxSync, rxByte[7:1]};  // lsb arrives first
                        bitIndex <= bitIndex + 3'd1;
                        if (bitIndex == 3'd7) state <= STOP_BIT;
                    end
                end
                default: begin
                    if (comTick) state <= WAIT_START;  // stop bit level ignored
                end
            endcase
        end
    end

    assign byteValid = (state == STOP_BIT) && comTick;

    singleCycleValid: assert property (@(posedge CLK) disable iff (!resetn)
        byteValid |=> !byteValid);

endmodule

// File: src/frameDecoder.sv
`timescale 1ns/1ps

// header detection, session timeout and payload decoding
module frameDecoder (
    input  logic       CLK,
    input  logic       resetn,
    input  logic [7:0] rxByte,
    input  logic       byteValid,
    output logic [7:0] dataByte,
    output logic       dataStrobe,
    output logic       frameStart,
    output logic       ComActive,
    output logic [7:0] Command
);
    import configUartPkg::*;

    // idle also takes the first id byte
    localparam logic [2:0] IDLE    = 3'd0;
    localparam logic [2:0] ID1     = 3'd1;
    localparam logic [2:0] ID2     = 3'd2;
    localparam logic [2:0] GET_CMD = 3'd3;
    localparam logic [2:0] EVAL    = 3'd4;
    localparam logic [2:0] PAYLOAD = 3'd5;

    logic [2:0]                       state;
    logic [23:0]                      idReg;
    logic [7:0]                       commandReg;
    logic [$bits(TIMEOUT_CYCLES)-1:0] timeoutCount;
    logic                             timedOut;
    logic                             headerOk;
    logic                             hexMode;
    logic [4:0]                       hexValue;  // bit 4 flags a non-hex character
    logic                             lowNext;
    logic [3:0]                       highNibble;

    function automatic logic [4:0] asciiToNibble(input logic [7:0] c);
        logic [4:0] result;
        if (c >= 8'h30 && c <= 8'h39) begin
            result = {1'b0, 4'(c - 8'h30)};
        end else if (c >= 8'h41 && c <= 8'h46) begin
            result = {1'b0, 4'(c - 8'h37)};  // A..F
        end else if (c >= 8'h61 && c <= 8'h66) begin
            result = {1'b0, 4'(c - 8'h57)};  // a..f
        end else begin
            result = 5'b10000;
        end
        return result;
    endfunction

    assign hexValue  = asciiToNibble(rxByte);
    assign hexMode   = commandReg[CMD_HEX_BIT];
    assign headerOk  = (idReg == HEADER_ID) &&
                       (commandReg[6:0] == CMD_LOAD_A || commandReg[6:0] == CMD_LOAD_B);
    assign timedOut  = (timeoutCount == '0);
    assign ComActive = (state == PAYLOAD);
    assign Command   = commandReg;

    // restarted by every received byte
    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            timeoutCount <= TIMEOUT_CYCLES - 1'b1;
        end else if (state == IDLE || byteValid) begin
            timeoutCount <= TIMEOUT_CYCLES - 1'b1;
        end else if (!timedOut) begin
            timeoutCount <= timeoutCount - 1'b1;
        end
    end

    // a byte arriving in the expiry cycle wins over the timeout
    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            state      <= IDLE;
            commandReg <= 8'h00;
            frameStart <= 1'b0;
        end else begin
            frameStart <= 1'b0;
            case (state)
                IDLE: begin
                    if (byteValid) state <= ID1;
                end
                ID1: begin
                    if (byteValid) state <= ID2;
                    else if (timedOut) state <= IDLE;
                end
                ID2: begin
                    if (byteValid) state <= GET_CMD;
                    else if (timedOut) state <= IDLE;
                end
                GET_CMD: begin
                    if (byteValid) begin
                        commandReg <= rxByte;
                        state      <= EVAL;
                    end else if (timedOut) begin
                        state <= IDLE;
                    end
                end
                EVAL: begin
                    if (headerOk) begin
                        state      <= PAYLOAD;
                        frameStart <= 1'b1;
                    end else begin
                        state <= IDLE;
                    end
                end
                PAYLOAD: begin
                    if (timedOut && !byteValid) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (byteValid) begin
            case (state)
                IDLE:    idReg[23:16] <= rxByte;
                ID1:     idReg[15:8]  <= rxByte;
                ID2:     idReg[7:0]   <= rxByte;
                default: ;
            endcase
        end
    end

    // nibble pairing is cleared outside the payload state
    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            dataStrobe <= 1'b0;
            lowNext    <= 1'b0;
        end else begin
            dataStrobe <= 1'b0;
            if (state != PAYLOAD) begin
                lowNext <= 1'b0;
            end else if (byteValid) begin
                if (!hexMode) begin
                    dataStrobe <= 1'b1;
                end else if (hexValue[4]) begin
                    lowNext <= 1'b0;  // junk character restarts the pair
                end else if (lowNext) begin
                    dataStrobe <= 1'b1;
                    lowNext    <= 1'b0;
                end else begin
                    lowNext <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (state == PAYLOAD && byteValid) begin
            if (!hexMode) begin
                dataByte <= rxByte;
            end else if (!hexValue[4]) begin
                if (lowNext) dataByte <= {highNibble, hexValue[3:0]};
                else highNibble <= hexValue[3:0];
            end
        end
    end

    frameStartFromEval: assert property (@(posedge CLK) disable iff (!resetn)
        frameStart |-> $past(state) == EVAL);

    strobeInSession: assert property (@(posedge CLK) disable iff (!resetn)
        dataStrobe |-> ComActive);

endmodule

// File: src/wordAssembler.sv
`timescale 1ns/1ps

// collects payload bytes msb first and publishes each full word
module wordAssembler (
    input  logic        CLK,
    input  logic        resetn,
    input  logic [7:0]  dataByte,
    input  logic        dataStrobe,
    input  logic        frameStart,
    output logic [31:0] WriteData,
    output logic        WriteStrobe
);
    import configUartPkg::*;

    localparam logic [1:0] LAST_POS = 2'(BYTES_PER_WORD - 1);

    logic [1:0]  bytePos;
    logic [23:0] partWord;  // upper three bytes of the word in progress

    always_ff @(posedge CLK or negedge resetn) begin
        if (!resetn) begin
            bytePos     <= 2'd0;
            partWord    <= 24'h000000;
            WriteData   <= 32'h00000000;
            WriteStrobe <= 1'b0;
        end else begin
            WriteStrobe <= 1'b0;
            if (frameStart) begin
                bytePos  <= 2'd0;
                partWord <= 24'h000000;
            end else if (dataStrobe) begin
                bytePos <= bytePos + 2'd1;  // wraps after the last byte
                if (bytePos == LAST_POS) begin
                    // output only moves when a word is complete
                    WriteData   <= {partWord, dataByte};
                    WriteStrobe <= 1'b1;
                end else begin
                    partWord[8*(2-bytePos) +: 8] <= dataByte;
                end
            end
        end
    end

    singleCycleStrobe: assert property (@(posedge CLK) disable iff (!resetn)
        WriteStrobe |=> !WriteStrobe);

endmodule

// File: src/configUart.sv
`timescale 1ns/1ps

// serial configuration loader built from receiver, decoder and word assembler
module configUart (
    input  logic        CLK,
    input  logic        resetn,
    input  logic        Rx,
    output logic [31:0] WriteData,
    output logic        WriteStrobe,
    output logic        ComActive,
    output logic [7:0]  Command
);

    logic [7:0] rxByte;
    logic       byteValid;
    logic [7:0] dataByte;
    logic       dataStrobe;
    logic       frameStart;

    uartByteReceiver receiver0 (
        .CLK       (CLK),
        .resetn    (resetn),
        .Rx        (Rx),
        .rxByte    (rxByte),
        .byteValid (byteValid)
    );

    frameDecoder decoder0 (
        .CLK        (CLK),
        .resetn     (resetn),
        .rxByte     (rxByte),
        .byteValid  (byteValid),
        .dataByte   (dataByte),
        .dataStrobe (dataStrobe),
        .frameStart (frameStart),
        .ComActive  (ComActive),
        .Command    (Command)
    );

    wordAssembler assembler0 (
        .CLK         (CLK),
        .resetn      (resetn),
        .dataByte    (dataByte),
        .dataStrobe  (dataStrobe),
        .frameStart  (frameStart),
        .WriteData   (WriteData),
        .WriteStrobe (WriteStrobe)
    );

endmodule

// File: verification/configUartTb.sv
`timescale 1ns/1ps

module configUartTb;
    import configUartPkg::*;

    localparam int NUM_TESTS = 8;
    localparam int WORD_WAIT_LIMIT = 40 * COM_RATE;  // cycles
    localparam int GAP_CYCLES = TIMEOUT_CYCLES + 20;  // longer than the session timeout

    logic        CLK;
    logic        resetn;
    logic        Rx;
    logic [31:0] WriteData;
    logic        WriteStrobe;
    logic        ComActive;
    logic [7:0]  Command;

    // stimulus table with one row per test
    string        testNames[NUM_TESTS];
    logic [31:0]  headers[NUM_TESTS];   // three id bytes and the command byte
    logic [127:0] payloads[NUM_TESTS];  // sent from the top used byte down
    int           payloadLens[NUM_TESTS];
    int           wordCounts[NUM_TESTS];
    logic [63:0]  expWords[NUM_TESTS];  // first word in the upper half
    bit           expActive[NUM_TESTS];
    bit           longGap[NUM_TESTS];

    logic [31:0] gotWords[$];
    int          errorCount = 0;
    int          passCount = 0;
    int          failCount = 0;

    configUart dut0 (
        .CLK         (CLK),
        .resetn      (resetn),
        .Rx          (Rx),
        .WriteData   (WriteData),
        .WriteStrobe (WriteStrobe),
        .ComActive   (ComActive),
        .Command     (Command)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // word monitor
    always @(posedge CLK) begin
        if (WriteStrobe) gotWords.push_back(WriteData);
    end

    task automatic waitCycles(input int n);
        repeat (n) @(posedge CLK);
        #1;  // inputs move just after the edge
    endtask

    task automatic sendBit(input logic value);
        Rx = value;
        waitCycles(COM_RATE);
    endtask

    // start bit, data lsb first, stop bit and two idle bits
    task automatic sendByte(input logic [7:0] value);
        sendBit(1'b0);
        for (int i = 0; i < 8; i++) sendBit(value[i]);
        repeat (3) sendBit(1'b1);
    endtask

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            errorCount++;
        end
    endtask

    task automatic waitForWords(input int count);
        int cycles;
        cycles = 0;
        while (gotWords.size() < count && cycles < WORD_WAIT_LIMIT) begin
            waitCycles(1);
            cycles++;
        end
        if (gotWords.size() < count) begin
            $display("timeout: WriteStrobe came %0d times, %0d words were due",
                     gotWords.size(), count);
            errorCount++;
        end
    endtask

    task automatic setRow(input int t, input string name, input logic [31:0] header,
                          input logic [127:0] payload, input int len, input int count,
                          input logic [63:0] words, input bit active, input bit gap);
        testNames[t]   = name;
        headers[t]     = header;
        payloads[t]    = payload;
        payloadLens[t] = len;
        wordCounts[t]  = count;
        expWords[t]    = words;
        expActive[t]   = active;
        longGap[t]     = gap;
    endtask

    task automatic fillTable();
        setRow(0, "binary load", 32'h00AAFF01, 128'h1122334455667788, 8, 2,
               64'h11223344_55667788, 1'b1, 1'b1);
        setRow(1, "hex load", 32'h00AAFF82, "DEADbeef0123abCD", 16, 2,
               64'hDEADBEEF_0123ABCD, 1'b1, 1'b1);
        setRow(2, "invalid hex characters", 32'h00AAFF81, "12xx34,56-78", 12, 1,
               64'h12345678_00000000, 1'b1, 1'b1);
        // leftover bytes stop short of a command byte
        setRow(3, "wrong id", 32'h00ABFF01, 128'h112233, 3, 0, 64'h0, 1'b0, 1'b1);
        setRow(4, "unaccepted code", 32'h00AAFF03, 128'h0, 0, 0, 64'h0, 1'b0, 1'b0);
        setRow(5, "timeout with partial word", 32'h00AAFF01, 128'hA1A2A3A4B1B2, 6, 1,
               64'hA1A2A3A4_00000000, 1'b1, 1'b1);
        setRow(6, "bytes without header", 32'h12345678, 128'h0, 0, 0, 64'h0, 1'b0, 1'b0);
        setRow(7, "load after timeout", 32'h00AAFF02, 128'hC1C2C3C4, 4, 1,
               64'hC1C2C3C4_00000000, 1'b1, 1'b1);
    endtask

    task automatic runTest(input int t);
        int          errorsBefore;
        logic [31:0] expected;
        errorsBefore = errorCount;
        gotWords.delete();
        for (int i = 3; i >= 0; i--) sendByte(headers[t][8*i +: 8]);
        checkValue("ComActive after header", 32'(ComActive), 32'(expActive[t]));
        for (int i = payloadLens[t] - 1; i >= 0; i--) sendByte(payloads[t][8*i +: 8]);
        waitForWords(wordCounts[t]);
        checkValue("ComActive after payload", 32'(ComActive), 32'(expActive[t]));
        if (longGap[t]) begin
            waitCycles(GAP_CYCLES);  // quiet line closes the session
            checkValue("ComActive after gap", 32'(ComActive), 32'd0);
        end
        checkValue("word count", gotWords.size(), wordCounts[t]);
        for (int w = 0; w < gotWords.size() && w < 2; w++) begin
            expected = expWords[t][32*(1-w) +: 32];
            checkValue($sformatf("word %0d", w), gotWords[w], expected);
        end
        // last captured command byte
        checkValue("Command", 32'(Command), 32'(headers[t][7:0]));
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("test %0d %s: passed", t, testNames[t]);
        end else begin
            failCount++;
            $display("test %0d %s: failed", t, testNames[t]);
        end
    endtask

    initial begin
        Rx = 1'b1;
        resetn = 1'b0;
        fillTable();
        repeat (3) @(posedge CLK);
        #1;
        resetn = 1'b1;
        waitCycles(4);
        for (int t = 0; t < NUM_TESTS; t++) runTest(t);
        $display("tests passed: %0d, tests failed: %0d", passCount, failCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // whole run needs about 11 ms
    initial begin
        #50_000_000;
        $display("simulation ran past its time limit, tests did not complete");
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: all.f
src/configUartPkg.sv
src/uartByteReceiver.sv
src/frameDecoder.sv
src/wordAssembler.sv
src/configUart.sv
verification/configUartTb.sv

// File: Makefile
VERILATOR       ?= verilator
TOP             ?= configUartTb
RTL_TOP         ?= configUart
SIM_DIR         ?= obj_dir
FILE_LIST       ?= all.f
LOG             ?= sim.log
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS      ?= --lint-only -Wall
RTL_SRCS        ?= src/configUartPkg.sv src/uartByteReceiver.sv src/frameDecoder.sv \
                   src/wordAssembler.sv src/configUart.sv
PASS_TEXT       := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(SIM_DIR) -f $(FILE_LIST)

run: build
	./$(SIM_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(SIM_DIR) $(LOG)
